/* verif/decoder_cases.txt */
# name instr illegal_c ctrl exc, all values hex
# ctrl is dec_ctrl_t (26 bits), exc is illegal,ecall,ebreak,eret,wfi
add            002081B3 0 0003800 00
sub            402081B3 0 0203800 00
sra            407352B3 0 0E03800 00
op_mul_bad     023100B3 0 1203000 10
addi           00500093 0 0042800 00
xori           FFF0C113 0 0442800 00
slli           00309093 0 0A42800 00
slli_bad_f7    40309093 0 0A42000 10
srli_bad_f7    0240D093 0 1242000 10
lw             0080A283 0 0042620 00
lbu            0000C283 0 0042680 00
lh             00209283 0 0042660 00
load_011_bad   0000B283 0 0042020 10
load_110_bad   0000E283 0 0042000 10
sb             00208223 0 0047380 00
sw             0020A423 0 0047300 00
store_11_bad   0020B223 0 0047000 10
jal            010000EF 0 00CC808 00
jalr           000100E7 0 00CE810 00
jalr_f3_bad    000110E7 0 00CE000 10
beq            00208463 0 1403018 00
bgeu           0020F463 0 1E03018 00
branch_010_bad 0020A463 0 1203000 10
lui            123450B7 0 0148800 00
auipc          00001117 0 00C8800 00
ecall          00000073 0 1200000 08
ebreak         00100073 0 1200000 04
eret           10000073 0 1200000 02
wfi            10200073 0 1200000 01
system_bad     00200073 0 1200000 10
csrrw          300110F3 0 1262805 00
csrrsi         3002E0F3 0 1360806 00
csrrc          300130F3 0 1262807 00
csr_f3_100_bad 300140F3 0 1360000 10
illc_add       002081B3 1 0003000 10
illc_ecall     00000073 1 1200000 10
unknown_opcode 0000000B 0 1200000 10

/* build.f */
hw/dec_pkg.sv
hw/instr_stage.sv
hw/alu_lsu_decode.sv
hw/sys_decode.sv
hw/ctrl_gate.sv
hw/riscv_decoder_top.sv
verif/tb_clk_gen.sv
verif/tb_decoder.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the decoder testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_decoder -f build.f -o Vtb_decoder
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/Vtb_decoder > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0

/* verif/tb_decoder.sv */
`timescale 1ns/1ps

module tb_decoder;

  localparam int ACCEPT_LIMIT = 200;   // cycles per input word
  localparam int DRAIN_LIMIT  = 2000;  // cycles for the tail of the stream
  localparam int RESET_LIMIT  = 50;
  localparam int IDLE_CYCLES  = 20;    // quiet window at the end

  logic               clk;
  logic               rst_n;
  logic               in_valid;
  dec_pkg::in_item_t  in_item;
  logic               in_ready;
  logic               out_valid;
  dec_pkg::dec_ctrl_t out_ctrl;
  dec_pkg::dec_exc_t  out_exc;
  logic               out_ready;

  // expected stream in file order
  string              case_name[$];
  dec_pkg::in_item_t  case_in[$];
  dec_pkg::dec_ctrl_t case_ctrl[$];
  dec_pkg::dec_exc_t  case_exc[$];

  int                 out_count  = 0;
  logic [31:0]        lfsr_state = 32'd68989;
  logic               held_valid = 1'b0;  // output was stalled last cycle
  dec_pkg::dec_ctrl_t held_ctrl;
  dec_pkg::dec_exc_t  held_exc;

  tb_clk_gen #(
    .HALF_PERIOD  (10),
    .RESET_CYCLES (8)
  ) u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  riscv_decoder_top dut_i (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .valid_i (in_valid),
    .in_i    (in_item),
    .ready_o (in_ready),
    .valid_o (out_valid),
    .ctrl_o  (out_ctrl),
    .exc_o   (out_exc),
    .ready_i (out_ready)
  );

  ////////////////////
  // helpers
  ////////////////////

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_ctrl(input string name, input dec_pkg::dec_ctrl_t exp_ctrl,
                            input dec_pkg::dec_ctrl_t act_ctrl);
    if (act_ctrl !== exp_ctrl) begin
      report_failure($sformatf("Error %s: ctrl expected %h actual %h",
                               name, exp_ctrl, act_ctrl));
    end
  endtask

  task automatic check_exc(input string name, input dec_pkg::dec_exc_t exp_exc,
                           input dec_pkg::dec_exc_t act_exc);
    if (act_exc !== exp_exc) begin
      report_failure($sformatf("Error %s: exc expected %h actual %h",
                               name, exp_exc, act_exc));
    end
  endtask

  // one case per line and '#' lines skipped
  task automatic load_cases();
    int                 fd;
    int                 rc;
    int                 c;
    string              name;
    logic [31:0]        word;
    logic [31:0]        ic;
    logic [31:0]        ctrl;
    logic [31:0]        exc;
    dec_pkg::in_item_t  item;
    dec_pkg::dec_ctrl_t exp_c;
    dec_pkg::dec_exc_t  exp_e;
    fd = $fopen("verif/decoder_cases.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open verif/decoder_cases.txt");
    end
    while (!$feof(fd)) begin
      rc = $fscanf(fd, "%s", name);
      if (rc == 1) begin
        if (name.getc(0) == 8'h23) begin
          c = $fgetc(fd);
          while (c != 10 && c != -1) begin  // eat the rest of the line
            c = $fgetc(fd);
          end
        end else begin
          rc = $fscanf(fd, "%h %h %h %h", word, ic, ctrl, exc);
          if (rc != 4) begin
            report_failure({"cases file line for ", name, " is incomplete"});
          end
          item.instr     = word;
          item.illegal_c = ic[0];
          exp_c          = ctrl[25:0];
          exp_e          = exc[4:0];
          case_name.push_back(name);
          case_in.push_back(item);
          case_ctrl.push_back(exp_c);
          case_exc.push_back(exp_e);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic wait_reset_release();
    int waited;
    waited = 0;
    while (rst_n !== 1'b1) begin
      if (waited >= RESET_LIMIT) begin
        report_failure("reset was never released");
      end
      @(negedge clk);
      waited++;
    end
  endtask

  // runs from posedge + 2 ns to posedge + 2 ns after the transfer
  task automatic send_item(input dec_pkg::in_item_t item);
    int waited;
    waited   = 0;
    in_item  = item;
    in_valid = 1'b1;
    @(negedge clk);
    while (in_ready !== 1'b1) begin  // ready_o settles before the next edge
      if (waited >= ACCEPT_LIMIT) begin
        report_failure("ready_o stayed low, an input word was never accepted");
      end
      @(negedge clk);
      waited++;
    end
    @(posedge clk);  // transfer edge
    #2;
  endtask

  ////////////////////
  // core stall
  ////////////////////

  always @(posedge clk) begin
    if (rst_n === 1'b1) begin  // rst_n only moves between edges
      #2;
      lfsr_state = lfsr_next(lfsr_state);
      out_ready  = lfsr_state[0];  // one step per bit
    end
  end

  ////////////////////
  // monitor
  ////////////////////

  // sampled mid-cycle where values hold up to the next edge
  always @(negedge clk) begin
    if (rst_n === 1'b1) begin
      if (out_valid === 1'b1 && out_count >= case_name.size()) begin
        report_failure("DUT produced an output after the last case");
      end
      if (held_valid) begin
        if (out_valid !== 1'b1) begin
          report_failure("valid_o dropped while the core stalled");
        end
        check_ctrl({case_name[out_count], " held"}, held_ctrl, out_ctrl);
        check_exc({case_name[out_count], " held"}, held_exc, out_exc);
      end
      held_valid = out_valid && !out_ready;
      held_ctrl  = out_ctrl;
      held_exc   = out_exc;
      if (out_valid && out_ready) begin  // transfers at the next edge
        check_ctrl(case_name[out_count], case_ctrl[out_count], out_ctrl);
        check_exc(case_name[out_count], case_exc[out_count], out_exc);
        out_count++;
      end
    end
  end

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    int idx;
    int waited;
    in_valid  = 1'b0;
    in_item   = '0;
    out_ready = 1'b0;
    load_cases();
    wait_reset_release();
    @(negedge clk);
    if (out_valid !== 1'b0) begin
      report_failure("valid_o is high right after reset");
    end
    @(posedge clk);
    #2;
    for (idx = 0; idx < case_in.size(); idx++) begin
      send_item(case_in[idx]);
    end
    in_valid = 1'b0;
    waited   = 0;
    while (out_count < case_name.size()) begin
      if (waited >= DRAIN_LIMIT) begin
        report_failure("outputs stopped before every case came out");
      end
      @(negedge clk);
      waited++;
    end
    repeat (IDLE_CYCLES) @(negedge clk);  // no stray output may follow
    if (out_count == case_name.size() && case_name.size() > 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      report_failure("no cases were read or the output count is off");
    end
  end

endmodule

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HALF_PERIOD  = 10,  // ns
  parameter int RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // release a little after the edge, away from the DUT flops
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2;
    rst_n_o = 1'b1;
  end

endmodule

/* hw/riscv_decoder_top.sv */
`timescale 1ns/1ps

module riscv_decoder_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // instruction stream in
  input  logic               valid_i,
  input  dec_pkg::in_item_t  in_i,
  output logic               ready_o,
  // decoded stream out
  output logic               valid_o,
  output dec_pkg::dec_ctrl_t ctrl_o,
  output dec_pkg::dec_exc_t  exc_o,
  input  logic               ready_i
);

  dec_pkg::in_item_t  item;
  logic               item_valid;
  logic               stage_ready;
  dec_pkg::dec_ctrl_t main_ctrl;
  logic               main_illegal;
  dec_pkg::csr_op_e   csr_op;
  dec_pkg::dec_exc_t  sys_exc;

  instr_stage u_instr_stage (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .valid_i       (valid_i),
    .in_i          (in_i),
    .ready_o       (ready_o),
    .item_o        (item),
    .item_valid_o  (item_valid),
    .stage_ready_i (stage_ready)
  );

  // both decoders look at the same held word
  alu_lsu_decode u_alu_lsu_decode (
    .instr_i   (item.instr),
    .ctrl_o    (main_ctrl),
    .illegal_o (main_illegal)
  );

  sys_decode u_sys_decode (
    .instr_i  (item.instr),
    .csr_op_o (csr_op),
    .exc_o    (sys_exc)
  );

  ctrl_gate u_ctrl_gate (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .item_valid_i   (item_valid),
    .illegal_c_i    (item.illegal_c),
    .main_ctrl_i    (main_ctrl),
    .main_illegal_i (main_illegal),
    .csr_op_i       (csr_op),
    .sys_exc_i      (sys_exc),
    .stage_ready_o  (stage_ready),
    .valid_o        (valid_o),
    .ctrl_o         (ctrl_o),
    .exc_o          (exc_o),
    .ready_i        (ready_i)
  );

endmodule

/* hw/ctrl_gate.sv */
`timescale 1ns/1ps

module ctrl_gate (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               item_valid_i,
  input  logic               illegal_c_i,
  input  dec_pkg::dec_ctrl_t main_ctrl_i,
  input  logic               main_illegal_i,
  input  dec_pkg::csr_op_e   csr_op_i,
  input  dec_pkg::dec_exc_t  sys_exc_i,
  output logic               stage_ready_o,
  // downstream stream
  output logic               valid_o,
  output dec_pkg::dec_ctrl_t ctrl_o,
  output dec_pkg::dec_exc_t  exc_o,
  input  logic               ready_i       // low = core stall
);

  dec_pkg::dec_ctrl_t ctrl_d, ctrl_q;
  dec_pkg::dec_exc_t  exc_d, exc_q;
  logic               valid_q;

  ////////////////////
  // merge and kill
  ////////////////////

  always_comb begin
    ctrl_d         = main_ctrl_i;
    ctrl_d.csr_op  = csr_op_i;
    exc_d          = sys_exc_i;
    exc_d.illegal  = main_illegal_i | sys_exc_i.illegal | illegal_c_i;

    // illegal instruction leaves no trace in the core
    if (exc_d.illegal) begin
      ctrl_d.regfile_alu_we = 1'b0;
      ctrl_d.regfile_mem_we = 1'b0;
      ctrl_d.data_req       = 1'b0;
      ctrl_d.data_we        = 1'b0;
      ctrl_d.jump           = dec_pkg::BRANCH_NONE;
      ctrl_d.csr_access     = 1'b0;
      ctrl_d.csr_op         = dec_pkg::CSR_OP_NONE;
      exc_d.ecall           = 1'b0;
      exc_d.ebreak          = 1'b0;
      exc_d.eret            = 1'b0;
      exc_d.wfi             = 1'b0;
    end
  end

  ////////////////////
  // output register
  ////////////////////

  assign stage_ready_o = ~valid_q | ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (stage_ready_o) begin
      valid_q <= item_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (stage_ready_o && item_valid_i) begin
      ctrl_q <= ctrl_d;
      exc_q  <= exc_d;
    end
  end

  assign valid_o = valid_q;
  assign ctrl_o  = ctrl_q;
  assign exc_o   = exc_q;

  ////////////////////
  // checks
  ////////////////////

  a_stall_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(ctrl_o) && $stable(exc_o));

  // no write side effect leaves with an illegal flag
  a_no_we_on_illegal : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && exc_o.illegal |-> !(ctrl_o.regfile_alu_we || ctrl_o.regfile_mem_we ||
                                   ctrl_o.data_req || ctrl_o.data_we));

  a_one_sys_flag : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o |-> $onehot0({exc_o.ecall, exc_o.ebreak, exc_o.eret, exc_o.wfi}));

endmodule

/* hw/sys_decode.sv */
`timescale 1ns/1ps

module sys_decode (
  input  dec_pkg::instr_t  instr_i,
  output dec_pkg::csr_op_e csr_op_o,
  output dec_pkg::dec_exc_t exc_o
);

  logic is_system;

  assign is_system = (instr_i.i_fmt.opcode == dec_pkg::OPCODE_SYSTEM);

  always_comb begin
    csr_op_o = dec_pkg::CSR_OP_NONE;
    exc_o    = '0;

    if (is_system) begin
      if (instr_i.i_fmt.funct3 == 3'b000) begin
        // privileged ops, full word match
        case (instr_i)
          32'h0000_0073: exc_o.ecall  = 1'b1;
          32'h0010_0073: exc_o.ebreak = 1'b1;  // debugger trap
          32'h1000_0073: exc_o.eret   = 1'b1;
          32'h1020_0073: exc_o.wfi    = 1'b1;  // pipe flush in core
          default:       exc_o.illegal = 1'b1;
        endcase
      end else begin
        // csr access, bit 14 only picks reg or uimm
        case (instr_i.i_fmt.funct3[1:0])
          2'b01:   csr_op_o      = dec_pkg::CSR_OP_WRITE;
          2'b10:   csr_op_o      = dec_pkg::CSR_OP_SET;
          2'b11:   csr_op_o      = dec_pkg::CSR_OP_CLEAR;
          default: exc_o.illegal = 1'b1;  // funct3 100
        endcase
      end
    end
  end

endmodule

/* hw/alu_lsu_decode.sv */
`timescale 1ns/1ps

module alu_lsu_decode (
  input  dec_pkg::instr_t    instr_i,
  output dec_pkg::dec_ctrl_t ctrl_o,
  output logic               illegal_o
);

  logic [2:0] funct3;
  logic [6:0] funct7;

  assign funct3 = instr_i.i_fmt.funct3;
  assign funct7 = instr_i.r_fmt.funct7;  // also shamt upper bits in OP-IMM

  always_comb begin
    // safe defaults, nothing written
    ctrl_o           = '0;
    ctrl_o.alu_op    = dec_pkg::ALU_SLTU;
    ctrl_o.op_a_sel  = dec_pkg::OP_A_REGA;
    ctrl_o.op_b_sel  = dec_pkg::OP_B_REGB;
    ctrl_o.imm_a_sel = dec_pkg::IMMA_ZERO;
    ctrl_o.imm_b_sel = dec_pkg::IMMB_I;
    ctrl_o.data_type = dec_pkg::DT_WORD;
    ctrl_o.jump      = dec_pkg::BRANCH_NONE;
    ctrl_o.csr_op    = dec_pkg::CSR_OP_NONE;  // filled in by sys_decode path
    illegal_o        = 1'b0;

    case (instr_i.r_fmt.opcode)

      ////////////////////
      // jumps
      ////////////////////

      dec_pkg::OPCODE_JAL: begin
        ctrl_o.jump           = dec_pkg::BRANCH_JAL;
        ctrl_o.op_a_sel       = dec_pkg::OP_A_CURRPC;  // rd = pc + 4
        ctrl_o.op_b_sel       = dec_pkg::OP_B_IMM;
        ctrl_o.imm_b_sel      = dec_pkg::IMMB_PCINCR;
        ctrl_o.alu_op         = dec_pkg::ALU_ADD;
        ctrl_o.regfile_alu_we = 1'b1;
      end

      dec_pkg::OPCODE_JALR: begin
        ctrl_o.jump           = dec_pkg::BRANCH_JALR;
        ctrl_o.op_a_sel       = dec_pkg::OP_A_CURRPC;
        ctrl_o.op_b_sel       = dec_pkg::OP_B_IMM;
        ctrl_o.imm_b_sel      = dec_pkg::IMMB_PCINCR;
        ctrl_o.alu_op         = dec_pkg::ALU_ADD;
        ctrl_o.regfile_alu_we = 1'b1;
        ctrl_o.rega_used      = 1'b1;  // target base
        if (funct3 != 3'b000) begin
          ctrl_o.jump           = dec_pkg::BRANCH_NONE;
          ctrl_o.regfile_alu_we = 1'b0;
          illegal_o             = 1'b1;
        end
      end

      dec_pkg::OPCODE_BRANCH: begin
        ctrl_o.jump      = dec_pkg::BRANCH_COND;
        ctrl_o.rega_used = 1'b1;
        ctrl_o.regb_used = 1'b1;
        case (funct3)
          3'b000:  ctrl_o.alu_op = dec_pkg::ALU_EQ;
          3'b001:  ctrl_o.alu_op = dec_pkg::ALU_NE;
          3'b100:  ctrl_o.alu_op = dec_pkg::ALU_LTS;
          3'b101:  ctrl_o.alu_op = dec_pkg::ALU_GES;
          3'b110:  ctrl_o.alu_op = dec_pkg::ALU_LTU;
          3'b111:  ctrl_o.alu_op = dec_pkg::ALU_GEU;
          default: illegal_o     = 1'b1;  // 010, 011 unused
        endcase
      end

      ////////////////////
      // load / store
      ////////////////////

      dec_pkg::OPCODE_STORE: begin
        ctrl_o.data_req  = 1'b1;
        ctrl_o.data_we   = 1'b1;
        ctrl_o.rega_used = 1'b1;
        ctrl_o.regb_used = 1'b1;  // store data
        ctrl_o.alu_op    = dec_pkg::ALU_ADD;
        ctrl_o.op_b_sel  = dec_pkg::OP_B_IMM;
        ctrl_o.imm_b_sel = dec_pkg::IMMB_S;
        case (instr_i.s_fmt.funct3[1:0])
          2'b00:   ctrl_o.data_type = dec_pkg::DT_BYTE;  // sb
          2'b01:   ctrl_o.data_type = dec_pkg::DT_HALF;  // sh
          2'b10:   ctrl_o.data_type = dec_pkg::DT_WORD;  // sw
          default: begin
            ctrl_o.data_req = 1'b0;
            ctrl_o.data_we  = 1'b0;
            illegal_o       = 1'b1;
          end
        endcase
      end

      dec_pkg::OPCODE_LOAD: begin
        ctrl_o.data_req       = 1'b1;
        ctrl_o.regfile_mem_we = 1'b1;
        ctrl_o.rega_used      = 1'b1;
        ctrl_o.alu_op         = dec_pkg::ALU_ADD;
        ctrl_o.op_b_sel       = dec_pkg::OP_B_IMM;
        ctrl_o.imm_b_sel      = dec_pkg::IMMB_I;
        ctrl_o.data_sign_ext  = ~funct3[2];  // lbu/lhu zero-extend
        case (funct3)
          3'b000, 3'b100: ctrl_o.data_type = dec_pkg::DT_BYTE;
          3'b001, 3'b101: ctrl_o.data_type = dec_pkg::DT_HALF;
          3'b010:         ctrl_o.data_type = dec_pkg::DT_WORD;
          default:        illegal_o        = 1'b1;  // ld and unused slots
        endcase
      end

      ////////////////////
      // alu
      ////////////////////

      dec_pkg::OPCODE_LUI: begin
        ctrl_o.op_a_sel       = dec_pkg::OP_A_IMM;  // zero + U imm
        ctrl_o.op_b_sel       = dec_pkg::OP_B_IMM;
        ctrl_o.imm_a_sel      = dec_pkg::IMMA_ZERO;
        ctrl_o.imm_b_sel      = dec_pkg::IMMB_U;
        ctrl_o.alu_op         = dec_pkg::ALU_ADD;
        ctrl_o.regfile_alu_we = 1'b1;
      end

      dec_pkg::OPCODE_AUIPC: begin
        ctrl_o.op_a_sel       = dec_pkg::OP_A_CURRPC;
        ctrl_o.op_b_sel       = dec_pkg::OP_B_IMM;
        ctrl_o.imm_b_sel      = dec_pkg::IMMB_U;
        ctrl_o.alu_op         = dec_pkg::ALU_ADD;
        ctrl_o.regfile_alu_we = 1'b1;
      end

      dec_pkg::OPCODE_OPIMM: begin
        ctrl_o.op_b_sel       = dec_pkg::OP_B_IMM;
        ctrl_o.imm_b_sel      = dec_pkg::IMMB_I;
        ctrl_o.regfile_alu_we = 1'b1;
        ctrl_o.rega_used      = 1'b1;
        case (funct3)
          3'b000: ctrl_o.alu_op = dec_pkg::ALU_ADD;
          3'b010: ctrl_o.alu_op = dec_pkg::ALU_SLTS;
          3'b011: ctrl_o.alu_op = dec_pkg::ALU_SLTU;
          3'b100: ctrl_o.alu_op = dec_pkg::ALU_XOR;
          3'b110: ctrl_o.alu_op = dec_pkg::ALU_OR;
          3'b111: ctrl_o.alu_op = dec_pkg::ALU_AND;
          3'b001: begin
            ctrl_o.alu_op = dec_pkg::ALU_SLL;
            illegal_o     = (funct7 != 7'b0000000);
          end
          default: begin  // 101, srli or srai
            if (funct7 == 7'b0000000) begin
              ctrl_o.alu_op = dec_pkg::ALU_SRL;
            end else if (funct7 == 7'b0100000) begin
              ctrl_o.alu_op = dec_pkg::ALU_SRA;
            end else begin
              illegal_o = 1'b1;
            end
          end
        endcase
      end

      dec_pkg::OPCODE_OP: begin
        ctrl_o.regfile_alu_we = 1'b1;
        ctrl_o.rega_used      = 1'b1;
        ctrl_o.regb_used      = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: ctrl_o.alu_op = dec_pkg::ALU_ADD;
          {7'b0100000, 3'b000}: ctrl_o.alu_op = dec_pkg::ALU_SUB;
          {7'b0000000, 3'b010}: ctrl_o.alu_op = dec_pkg::ALU_SLTS;
          {7'b0000000, 3'b011}: ctrl_o.alu_op = dec_pkg::ALU_SLTU;
          {7'b0000000, 3'b100}: ctrl_o.alu_op = dec_pkg::ALU_XOR;
          {7'b0000000, 3'b110}: ctrl_o.alu_op = dec_pkg::ALU_OR;
          {7'b0000000, 3'b111}: ctrl_o.alu_op = dec_pkg::ALU_AND;
          {7'b0000000, 3'b001}: ctrl_o.alu_op = dec_pkg::ALU_SLL;
          {7'b0000000, 3'b101}: ctrl_o.alu_op = dec_pkg::ALU_SRL;
          {7'b0100000, 3'b101}: ctrl_o.alu_op = dec_pkg::ALU_SRA;
          default:              illegal_o     = 1'b1;  // M ext etc. not supported
        endcase
      end

      ////////////////////
      // csr operands
      ////////////////////

      dec_pkg::OPCODE_SYSTEM: begin
        // funct3 zero is ecall/ebreak/eret/wfi, flags come from sys_decode
        if (funct3 != 3'b000) begin
          ctrl_o.csr_access     = 1'b1;
          ctrl_o.regfile_alu_we = 1'b1;  // old csr value to rd
          ctrl_o.op_b_sel       = dec_pkg::OP_B_IMM;
          ctrl_o.imm_a_sel      = dec_pkg::IMMA_Z;
          ctrl_o.imm_b_sel      = dec_pkg::IMMB_I;  // csr address
          if (funct3[2]) begin
            ctrl_o.op_a_sel = dec_pkg::OP_A_IMM;  // csrr*i, uimm in rs1 field
          end else begin
            ctrl_o.op_a_sel  = dec_pkg::OP_A_REGA;
            ctrl_o.rega_used = 1'b1;
          end
        end
      end

      default: illegal_o = 1'b1;  // unknown opcode
    endcase
  end

endmodule

/* hw/instr_stage.sv */
`timescale 1ns/1ps

module instr_stage (
  input  logic             clk_i,
  input  logic             rst_n_i,
  // upstream stream
  input  logic             valid_i,
  input  dec_pkg::in_item_t in_i,
  output logic             ready_o,
  // towards decoders and ctrl_gate
  output dec_pkg::in_item_t item_o,
  output logic             item_valid_o,
  input  logic             stage_ready_i
);

  logic              valid_q;
  dec_pkg::in_item_t item_q;

  // free slot, or the slot drains this cycle
  assign ready_o = ~valid_q | stage_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;  // refill or go empty
    end
  end

  // payload only moves on a real transfer
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      item_q <= in_i;
    end
  end

  assign item_o       = item_q;
  assign item_valid_o = valid_q;

  ////////////////////
  // checks
  ////////////////////

  // held item must not change until ctrl_gate takes it
  a_hold_item : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    item_valid_o && !stage_ready_i |=> item_valid_o && $stable(item_o));

endmodule

/* hw/dec_pkg.sv */
package dec_pkg;

  ////////////////////
  // instruction word
  ////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;  // imm[11:5]
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;  // imm[4:0]
    logic [6:0] opcode;
  } s_fmt_t;

  // one word, three format views
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
  } instr_t;

  ////////////////////
  // encodings
  ////////////////////

  typedef enum logic [6:0] {
    OPCODE_LUI    = 7'b0110111,
    OPCODE_AUIPC  = 7'b0010111,
    OPCODE_JAL    = 7'b1101111,
    OPCODE_JALR   = 7'b1100111,
    OPCODE_BRANCH = 7'b1100011,
    OPCODE_LOAD   = 7'b0000011,
    OPCODE_STORE  = 7'b0100011,
    OPCODE_OPIMM  = 7'b0010011,
    OPCODE_OP     = 7'b0110011,
    OPCODE_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [4:0] {
    ALU_ADD  = 5'd0,
    ALU_SUB  = 5'd1,
    ALU_XOR  = 5'd2,
    ALU_OR   = 5'd3,
    ALU_AND  = 5'd4,
    ALU_SLL  = 5'd5,
    ALU_SRL  = 5'd6,
    ALU_SRA  = 5'd7,
    ALU_SLTS = 5'd8,
    ALU_SLTU = 5'd9,
    ALU_EQ   = 5'd10,  // branch compares from here on
    ALU_NE   = 5'd11,
    ALU_LTS  = 5'd12,
    ALU_GES  = 5'd13,
    ALU_LTU  = 5'd14,
    ALU_GEU  = 5'd15
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_A_REGA   = 2'd0,
    OP_A_CURRPC = 2'd1,
    OP_A_IMM    = 2'd2
  } op_a_sel_e;

  typedef enum logic {
    OP_B_REGB = 1'b0,
    OP_B_IMM  = 1'b1
  } op_b_sel_e;

  typedef enum logic [2:0] {
    IMMB_I      = 3'd0,
    IMMB_S      = 3'd1,
    IMMB_U      = 3'd2,
    IMMB_PCINCR = 3'd3
  } imm_b_sel_e;

  typedef enum logic {
    IMMA_ZERO = 1'b0,
    IMMA_Z    = 1'b1  // rs1 field zero-extended
  } imm_a_sel_e;

  typedef enum logic [1:0] {
    BRANCH_NONE = 2'd0,
    BRANCH_JAL  = 2'd1,
    BRANCH_JALR = 2'd2,
    BRANCH_COND = 2'd3
  } branch_e;

  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'd0,
    CSR_OP_WRITE = 2'd1,
    CSR_OP_SET   = 2'd2,
    CSR_OP_CLEAR = 2'd3
  } csr_op_e;

  typedef enum logic [1:0] {
    DT_WORD = 2'b00,
    DT_HALF = 2'b01,
    DT_BYTE = 2'b10
  } data_type_e;

  ////////////////////
  // control words
  ////////////////////

  typedef struct packed {
    alu_op_e    alu_op;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    imm_a_sel_e imm_a_sel;
    imm_b_sel_e imm_b_sel;
    logic       rega_used;
    logic       regb_used;
    logic       regfile_alu_we;
    logic       regfile_mem_we;
    logic       data_req;
    logic       data_we;
    data_type_e data_type;
    logic       data_sign_ext;
    branch_e    jump;
    logic       csr_access;
    csr_op_e    csr_op;
  } dec_ctrl_t;  // 26 bits

  typedef struct packed {
    logic illegal;
    logic ecall;
    logic ebreak;
    logic eret;
    logic wfi;
  } dec_exc_t;

  typedef struct packed {
    instr_t instr;
    logic   illegal_c;  // compressed decode failed in fetch
  } in_item_t;

endpackage
